//--- include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// machine word and register file size
`define RV_XLEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h8000_0000

// major opcodes, inst[6:0]
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_OP      7'b0110011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_SYSTEM  7'b1110011

// funct3, integer ALU
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SRL   3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// funct3, store width
`define RV_F3_SB    3'b000
`define RV_F3_SH    3'b001
`define RV_F3_SW    3'b010

`endif

//--- verilog/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // field layouts of one instruction word, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } rv_s_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    typedef union packed {
        logic [`RV_XLEN-1:0] raw;
        rv_r_fmt_t           r;
        rv_i_fmt_t           i;
        rv_s_fmt_t           s;
        rv_u_fmt_t           u;
        rv_j_fmt_t           j;
    } rv_inst_t;

    // nine classes need four bits
    typedef enum logic [3:0] {
        cls_op_imm, cls_op_reg, cls_lui, cls_auipc, cls_jal,
        cls_store, cls_ecall, cls_ebreak, cls_illegal
    } inst_class_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

endpackage

//--- verilog/inst_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module inst_decode import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  rv_inst_t            inst,
    output logic                dec_valid,
    output inst_class_t         dec_class,
    output alu_op_t             dec_alu_op,
    output logic [4:0]          dec_rs1,
    output logic [4:0]          dec_rs2,
    output logic [4:0]          dec_rd,
    output logic [`RV_XLEN-1:0] dec_imm,
    output logic [`RV_XLEN-1:0] dec_pc,
    output logic                dec_use_imm,
    output logic [2:0]          dec_funct3
);

    logic [`RV_XLEN-1:0] pc;
    logic                halted;
    logic                accept;
    inst_class_t         cls;
    alu_op_t             alu_op;
    logic [`RV_XLEN-1:0] imm;
    logic [4:0]          rs1;

    assign accept = inst_valid && !halted;

    // opcode classification, system split on the upper 25 bits
    always_comb begin
        case (inst.r.opcode)
            `RV_OPC_OP_IMM: cls = cls_op_imm;
            `RV_OPC_OP:     cls = cls_op_reg;
            `RV_OPC_LUI:    cls = cls_lui;
            `RV_OPC_AUIPC:  cls = cls_auipc;
            `RV_OPC_JAL:    cls = cls_jal;
            `RV_OPC_STORE:  cls = cls_store;
            `RV_OPC_SYSTEM: begin
                if (inst.raw[31:7] == 25'h0)
                    cls = cls_ecall;
                else if (inst.raw[31:7] == 25'h2000) // only bit 20 set
                    cls = cls_ebreak;
                else
                    cls = cls_illegal;
            end
            default:        cls = cls_illegal;
        endcase
    end

    // bit 30 picks sub and sra; sub only exists for register ops
    always_comb begin
        case (inst.r.funct3)
            `RV_F3_ADD:  alu_op = (cls == cls_op_reg && inst.raw[30]) ? alu_sub : alu_add;
            `RV_F3_SLL:  alu_op = alu_sll;
            `RV_F3_SLT:  alu_op = alu_slt;
            `RV_F3_SLTU: alu_op = alu_sltu;
            `RV_F3_XOR:  alu_op = alu_xor;
            `RV_F3_SRL:  alu_op = inst.raw[30] ? alu_sra : alu_srl;
            `RV_F3_OR:   alu_op = alu_or;
            default:     alu_op = alu_and;
        endcase
    end

    always_comb begin
        case (cls)
            cls_op_imm: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            cls_store:  imm = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
            cls_lui,
            cls_auipc:  imm = {inst.u.imm31_12, 12'h000};
            cls_jal:    imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                               inst.j.imm11, inst.j.imm10_1, 1'b0};
            default:    imm = '0;
        endcase
    end

    assign rs1 = (cls == cls_lui) ? 5'd0 : inst.r.rs1; // lui reads x0

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            halted    <= 1'b0;
            pc        <= `RV_RESET_PC;
        end else begin
            dec_valid <= accept;
            if (accept) begin
                pc <= (cls == cls_jal) ? pc + imm : pc + 32'd4;
                if (cls == cls_ebreak)
                    halted <= 1'b1; // no more strobes taken
            end
        end
    end

    // stage-1 payload
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_class   <= cls;
            dec_alu_op  <= alu_op;
            dec_rs1     <= rs1;
            dec_rs2     <= inst.r.rs2;
            dec_rd      <= inst.r.rd;
            dec_imm     <= imm;
            dec_pc      <= pc;
            dec_use_imm <= (cls == cls_op_imm);
            dec_funct3  <= inst.r.funct3;
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic                wr_en,
    input  logic [4:0]          wr_addr,
    input  logic [`RV_XLEN-1:0] wr_data,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    // x1..x31, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k < `RV_NREGS; k++)
                regs[k] <= '0;
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // reads are combinational
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module exec_unit import rv_pkg::*; (
    input  logic                dec_valid,
    input  inst_class_t         dec_class,
    input  alu_op_t             dec_alu_op,
    input  logic [4:0]          dec_rs1,
    input  logic [4:0]          dec_rs2,
    input  logic [4:0]          dec_rd,
    input  logic [`RV_XLEN-1:0] dec_imm,
    input  logic                dec_use_imm,
    input  logic [`RV_XLEN-1:0] dec_pc,
    input  logic [2:0]          dec_funct3,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic                ex_valid,
    output inst_class_t         ex_class,
    output logic [4:0]          ex_rd,
    output logic [`RV_XLEN-1:0] ex_result,
    output logic [`RV_XLEN-1:0] ex_store_addr,
    output logic [`RV_XLEN-1:0] ex_store_data,
    output logic [2:0]          ex_funct3,
    output logic [`RV_XLEN-1:0] ex_pc
);

    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_out;

    assign rs1 = dec_rs1;
    assign rs2 = dec_rs2;

    assign op_b  = dec_use_imm ? dec_imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_alu_op)
            alu_add:  alu_out = rs1_data + op_b;
            alu_sub:  alu_out = rs1_data - op_b;
            alu_sll:  alu_out = rs1_data << shamt;
            alu_slt:  alu_out = {31'd0, $signed(rs1_data) < $signed(op_b)};
            alu_sltu: alu_out = {31'd0, rs1_data < op_b};
            alu_xor:  alu_out = rs1_data ^ op_b;
            alu_srl:  alu_out = rs1_data >> shamt;
            alu_sra:  alu_out = $unsigned($signed(rs1_data) >>> shamt);
            alu_or:   alu_out = rs1_data | op_b;
            default:  alu_out = rs1_data & op_b;
        endcase
    end

    always_comb begin
        case (dec_class)
            cls_lui:   ex_result = dec_imm;
            cls_auipc: ex_result = dec_pc + dec_imm;
            cls_jal:   ex_result = dec_pc + 32'd4; // link
            default:   ex_result = alu_out;
        endcase
    end

    assign ex_store_addr = rs1_data + dec_imm;
    assign ex_store_data = rs2_data;

    assign ex_valid  = dec_valid;
    assign ex_class  = dec_class;
    assign ex_rd     = dec_rd;
    assign ex_funct3 = dec_funct3;
    assign ex_pc     = dec_pc;

endmodule

//--- verilog/retire_port.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module retire_port import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  inst_class_t         ex_class,
    input  logic [4:0]          ex_rd,
    input  logic [`RV_XLEN-1:0] ex_result,
    input  logic [`RV_XLEN-1:0] ex_store_addr,
    input  logic [`RV_XLEN-1:0] ex_store_data,
    input  logic [2:0]          ex_funct3,
    input  logic [`RV_XLEN-1:0] ex_pc,
    output logic                wr_en,
    output logic [4:0]          wr_addr,
    output logic [`RV_XLEN-1:0] wr_data,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic                store_valid,
    output logic [`RV_XLEN-1:0] store_addr,
    output logic [`RV_XLEN-1:0] store_data,
    output logic [1:0]          store_size,
    output logic                illegal,
    output logic                halt
);

    logic       has_rd;
    logic [1:0] size;

    assign has_rd = (ex_class == cls_op_imm) || (ex_class == cls_op_reg) ||
                    (ex_class == cls_lui) || (ex_class == cls_auipc) ||
                    (ex_class == cls_jal);

    // write lands on the same edge as retire_valid
    assign wr_en   = ex_valid && has_rd && (ex_rd != 5'd0);
    assign wr_addr = ex_rd;
    assign wr_data = ex_result;

    always_comb begin
        case (ex_funct3)
            `RV_F3_SB: size = 2'd0;
            `RV_F3_SH: size = 2'd1;
            `RV_F3_SW: size = 2'd2;
            default:   size = 2'd3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            store_valid  <= 1'b0;
            illegal      <= 1'b0;
            halt         <= 1'b0;
        end else begin
            retire_valid <= ex_valid && (ex_class != cls_illegal);
            store_valid  <= ex_valid && (ex_class == cls_store);
            illegal      <= ex_valid && (ex_class == cls_illegal);
            if (ex_valid && ex_class == cls_ebreak)
                halt <= 1'b1; // sticky
        end
    end

    always_ff @(posedge clk) begin
        retire_pc   <= ex_pc;
        retire_rd   <= wr_en ? ex_rd : 5'd0;
        retire_data <= wr_en ? ex_result : '0;
        store_addr  <= ex_store_addr;
        store_data  <= ex_store_data;
        store_size  <= size;
    end

endmodule

//--- verilog/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top import rv_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_valid,
    input  logic [`RV_XLEN-1:0] inst,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,
    output logic                store_valid,
    output logic [`RV_XLEN-1:0] store_addr,
    output logic [`RV_XLEN-1:0] store_data,
    output logic [1:0]          store_size,
    output logic                illegal,
    output logic                halt
);

    // decode stage registers
    logic                dec_valid;
    inst_class_t         dec_class;
    alu_op_t             dec_alu_op;
    logic [4:0]          dec_rs1;
    logic [4:0]          dec_rs2;
    logic [4:0]          dec_rd;
    logic [`RV_XLEN-1:0] dec_imm;
    logic [`RV_XLEN-1:0] dec_pc;
    logic                dec_use_imm;
    logic [2:0]          dec_funct3;

    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    // execute stage, combinational
    logic                ex_valid;
    inst_class_t         ex_class;
    logic [4:0]          ex_rd;
    logic [`RV_XLEN-1:0] ex_result;
    logic [`RV_XLEN-1:0] ex_store_addr;
    logic [`RV_XLEN-1:0] ex_store_data;
    logic [2:0]          ex_funct3;
    logic [`RV_XLEN-1:0] ex_pc;

    logic                wr_en;
    logic [4:0]          wr_addr;
    logic [`RV_XLEN-1:0] wr_data;

    inst_decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .dec_valid   (dec_valid),
        .dec_class   (dec_class),
        .dec_alu_op  (dec_alu_op),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_pc      (dec_pc),
        .dec_use_imm (dec_use_imm),
        .dec_funct3  (dec_funct3)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit i_exec (
        .dec_valid     (dec_valid),
        .dec_class     (dec_class),
        .dec_alu_op    (dec_alu_op),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_imm       (dec_imm),
        .dec_use_imm   (dec_use_imm),
        .dec_pc        (dec_pc),
        .dec_funct3    (dec_funct3),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .rs1           (rs1),
        .rs2           (rs2),
        .ex_valid      (ex_valid),
        .ex_class      (ex_class),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_addr (ex_store_addr),
        .ex_store_data (ex_store_data),
        .ex_funct3     (ex_funct3),
        .ex_pc         (ex_pc)
    );

    retire_port i_retire (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_class      (ex_class),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_addr (ex_store_addr),
        .ex_store_data (ex_store_data),
        .ex_funct3     (ex_funct3),
        .ex_pc         (ex_pc),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .store_size    (store_size),
        .illegal       (illegal),
        .halt          (halt)
    );

endmodule

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        ebreak;
        logic [31:0] cyc;
    } retire_rec_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  size;
        logic [31:0] cyc;
    } store_rec_t;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic [1:0]  store_size;
    logic        illegal;
    logic        halt;

    // reference model state
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    logic        model_halted;
    logic        exp_halt = 1'b0;
    logic [31:0] cyc = 32'd0;   // negedge count
    logic [31:0] issue_cyc;
    logic [31:0] rng;
    retire_rec_t ret_q[$];
    store_rec_t  st_q[$];
    logic [31:0] ill_q[$];

    rv_core_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .store_size   (store_size),
        .illegal      (illegal),
        .halt         (halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            abort($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // integer ops as the ISA defines them
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            `RV_F3_ADD:  return alt ? a - b : a + b;
            `RV_F3_SLL:  return a << b[4:0];
            `RV_F3_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
            `RV_F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `RV_F3_XOR:  return a ^ b;
            `RV_F3_SRL:  return alt ? (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]))
                                    : a >> b[4:0];
            `RV_F3_OR:   return a | b;
            default:     return a & b;
        endcase
    endfunction

    // compare every report against the queues, sampled mid-cycle
    always @(negedge clk) begin : monitor
        retire_rec_t r;
        store_rec_t  s;
        logic [31:0] c;
        cyc = cyc + 32'd1;
        if (!reset) begin
            if (retire_valid) begin
                if (ret_q.size() == 0) begin
                    abort("retire_valid seen with no instruction outstanding");
                end else begin
                    r = ret_q.pop_front();
                    check_val("retire cycle", cyc, r.cyc);
                    check_val("retire_pc", retire_pc, r.pc);
                    check_val("retire_rd", {27'd0, retire_rd}, {27'd0, r.rd});
                    check_val("retire_data", retire_data, r.data);
                    if (r.ebreak)
                        exp_halt = 1'b1;
                end
            end
            if (store_valid) begin
                if (st_q.size() == 0) begin
                    abort("store_valid seen with no store outstanding");
                end else begin
                    s = st_q.pop_front();
                    check_val("store cycle", cyc, s.cyc);
                    check_val("store_addr", store_addr, s.addr);
                    check_val("store_data", store_data, s.data);
                    check_val("store_size", {30'd0, store_size}, {30'd0, s.size});
                end
            end
            if (illegal) begin
                if (ill_q.size() == 0) begin
                    abort("illegal strobe seen for a legal instruction");
                end else begin
                    c = ill_q.pop_front();
                    check_val("illegal cycle", cyc, c);
                end
            end
            check_val("halt", {31'd0, halt}, {31'd0, exp_halt});
        end
    end

    task automatic drive_inst(input logic [31:0] word, output logic taken);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        taken      = !model_halted; // no acceptance after ebreak
        issue_cyc  = cyc;
    endtask

    task automatic expect_retire(input logic [4:0] rd, input logic writes,
                                 input logic [31:0] value, input logic [31:0] step,
                                 input logic is_ebreak);
        retire_rec_t r;
        r.pc     = model_pc;
        r.rd     = (writes && rd != 5'd0) ? rd : 5'd0;
        r.data   = (writes && rd != 5'd0) ? value : 32'd0;
        r.ebreak = is_ebreak;
        r.cyc    = issue_cyc + 32'd3;
        ret_q.push_back(r);
        if (writes && rd != 5'd0)
            model_regs[rd] = value;
        model_pc = model_pc + step;
        if (is_ebreak)
            model_halted = 1'b1;
    endtask

    task automatic do_imm(input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] res;
        logic        alt;
        logic        taken;
        alt = (f3 == `RV_F3_SRL) && imm[10]; // srai
        res = alu_ref(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm});
        drive_inst({imm, rs1, f3, rd, `RV_OPC_OP_IMM}, taken);
        if (taken)
            expect_retire(rd, 1'b1, res, 32'd4, 1'b0);
    endtask

    task automatic do_reg(input logic alt, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] res;
        logic        taken;
        res = alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]);
        drive_inst({1'b0, alt, 5'd0, rs2, rs1, f3, rd, `RV_OPC_OP}, taken);
        if (taken)
            expect_retire(rd, 1'b1, res, 32'd4, 1'b0);
    endtask

    task automatic do_upper(input logic is_auipc, input logic [4:0] rd,
                            input logic [19:0] imm);
        logic [31:0] res;
        logic        taken;
        res = is_auipc ? model_pc + {imm, 12'h000} : {imm, 12'h000};
        drive_inst({imm, rd, is_auipc ? `RV_OPC_AUIPC : `RV_OPC_LUI}, taken);
        if (taken)
            expect_retire(rd, 1'b1, res, 32'd4, 1'b0);
    endtask

    task automatic do_jal(input logic [4:0] rd, input logic [20:0] off);
        logic taken;
        drive_inst({off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL}, taken);
        if (taken)
            expect_retire(rd, 1'b1, model_pc + 32'd4, {{11{off[20]}}, off}, 1'b0);
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [11:0] imm);
        store_rec_t s;
        logic       taken;
        s.addr = model_regs[rs1] + {{20{imm[11]}}, imm};
        s.data = model_regs[rs2];
        s.size = f3[1:0];
        drive_inst({imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE}, taken);
        if (taken) begin
            s.cyc = issue_cyc + 32'd3;
            st_q.push_back(s);
            expect_retire(5'd0, 1'b0, 32'd0, 32'd4, 1'b0);
        end
    endtask

    task automatic do_system(input logic [31:0] word, input logic is_ebreak);
        logic taken;
        drive_inst(word, taken);
        if (taken)
            expect_retire(5'd0, 1'b0, 32'd0, 32'd4, is_ebreak);
    endtask

    task automatic do_illegal(input logic [31:0] word);
        logic taken;
        drive_inst(word, taken);
        if (taken) begin
            ill_q.push_back(issue_cyc + 32'd3);
            model_pc = model_pc + 32'd4; // still takes a pc slot
        end
    endtask

    // full 32-bit random value via lui then xori
    task automatic load_rand(input logic [4:0] rd);
        logic [31:0] r;
        r = next_rand();
        do_upper(1'b0, rd, r[31:12]);
        do_imm(`RV_F3_XOR, rd, rd, r[11:0]);
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        inst_valid <= 1'b0;
        n = 0;
        while (ret_q.size() != 0 || st_q.size() != 0 || ill_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 20)
                abort("timeout waiting for outstanding instructions to retire");
        end
    endtask

    task automatic test_imm();
        logic [31:0] r;
        r = next_rand();
        do_imm(`RV_F3_ADD, 5'd1, 5'd0, r[11:0]);
        do_imm(`RV_F3_ADD, 5'd2, 5'd0, {1'b1, r[22:12]}); // negative
        r = next_rand();
        do_imm(`RV_F3_SLT, 5'd3, 5'd2, r[11:0]);
        do_imm(`RV_F3_SLTU, 5'd4, 5'd1, r[23:12]);
        r = next_rand();
        do_imm(`RV_F3_XOR, 5'd5, 5'd2, r[11:0]);
        do_imm(`RV_F3_OR, 5'd6, 5'd1, r[23:12]);
        r = next_rand();
        do_imm(`RV_F3_AND, 5'd7, 5'd2, r[11:0]);
        do_imm(`RV_F3_SLL, 5'd8, 5'd1, {7'b0000000, r[16:12]});
        do_imm(`RV_F3_SRL, 5'd9, 5'd2, {7'b0000000, r[21:17]});
        do_imm(`RV_F3_SRL, 5'd10, 5'd2, {7'b0100000, r[26:22]}); // srai
        drain();
    endtask

    task automatic test_reg();
        load_rand(5'd12);
        load_rand(5'd13);
        do_reg(1'b0, `RV_F3_ADD, 5'd14, 5'd12, 5'd13);
        do_reg(1'b1, `RV_F3_ADD, 5'd15, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_SLL, 5'd16, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_SLT, 5'd17, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_SLTU, 5'd18, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_XOR, 5'd19, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_SRL, 5'd20, 5'd12, 5'd13);
        do_reg(1'b1, `RV_F3_SRL, 5'd21, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_OR, 5'd22, 5'd12, 5'd13);
        do_reg(1'b0, `RV_F3_AND, 5'd23, 5'd12, 5'd13);
        // each one reads the result retired just before it
        do_reg(1'b0, `RV_F3_ADD, 5'd24, 5'd14, 5'd15);
        do_reg(1'b1, `RV_F3_ADD, 5'd25, 5'd24, 5'd12);
        do_reg(1'b0, `RV_F3_XOR, 5'd24, 5'd25, 5'd24);
        drain();
    endtask

    task automatic test_upper_jal();
        logic [31:0] r;
        r = next_rand();
        do_upper(1'b0, 5'd26, r[31:12]);
        r = next_rand();
        do_upper(1'b1, 5'd27, r[31:12]);
        do_jal(5'd28, 21'h000010);
        do_upper(1'b1, 5'd29, 20'h00000); // pc of the jump target
        do_jal(5'd0, 21'h1ffff8);         // backwards, link dropped
        do_imm(`RV_F3_ADD, 5'd30, 5'd28, 12'h000);
        drain();
    endtask

    task automatic test_store();
        logic [31:0] r;
        r = next_rand();
        do_store(`RV_F3_SB, 5'd12, 5'd13, {r[11:5], 5'd14}); // rd field names x14
        do_store(`RV_F3_SH, 5'd13, 5'd12, {r[22:16], 5'd15});
        do_store(`RV_F3_SW, 5'd2, 5'd1, r[31:20]);
        do_reg(1'b0, `RV_F3_OR, 5'd30, 5'd14, 5'd0);
        do_reg(1'b0, `RV_F3_OR, 5'd31, 5'd15, 5'd0);
        drain();
    endtask

    task automatic test_x0_ill_ecall();
        logic [31:0] r;
        do_imm(`RV_F3_ADD, 5'd0, 5'd0, 12'h07b);
        do_reg(1'b0, `RV_F3_ADD, 5'd31, 5'd0, 5'd0);
        do_illegal({25'd0, 7'b0000011}); // load opcode
        r = next_rand();
        do_illegal({r[31:7], 7'b1100111}); // jalr
        do_system(32'h0000_0073, 1'b0);
        do_reg(1'b0, `RV_F3_OR, 5'd31, 5'd12, 5'd0);
        drain();
    endtask

    task automatic test_ebreak();
        do_system(32'h0010_0073, 1'b1);
        do_imm(`RV_F3_ADD, 5'd1, 5'd0, 12'h001);
        do_reg(1'b0, `RV_F3_ADD, 5'd2, 5'd12, 5'd13);
        do_system(32'h0000_0073, 1'b0);
        drain();
        for (int k = 0; k < 20; k++) begin
            @(posedge clk);
            if (retire_valid)
                abort("instruction retired after ebreak");
        end
        check_val("halt", {31'd0, halt}, 32'd1);
    endtask

    initial begin
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = 32'd0;
        rng          = 32'd9060;
        model_pc     = `RV_RESET_PC;
        model_halted = 1'b0;
        for (int k = 0; k < 32; k++)
            model_regs[k] = 32'd0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_imm();
        test_reg();
        test_upper_jal();
        test_store();
        test_x0_ill_ecall();
        test_ebreak();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
verilog/rv_pkg.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/retire_port.sv
verilog/rv_core_top.sv
dv/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the core with its testbench, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module rv_core_tb -o rv_core_sim &&
./obj_dir/rv_core_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
